// File: Makefile
TOP := tb_fifo

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the FIFO testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f sources.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: fifo_checker.sv
`timescale 1ns/1ns

// Handshake and occupancy rules, checked inside the pop control
module fifo_checker #(
  parameter int CW = 5
) (
  input logic          clk,
  input logic          rst_n,
  input logic [CW-1:0] occupancy,
  input logic [CW-1:0] capacity,
  input logic          bypass_ready,
  input logic          pop_valid,
  input logic          pop_ready
);

  // ----------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------

  // Stored entries never exceed the window size
  a_occ_in_window: assert property (@(posedge clk) disable iff (!rst_n)
    occupancy <= capacity)
    else $error("occupancy %0d above capacity %0d", occupancy, capacity);

  // Bypass is only legal while nothing is stored
  a_bypass_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
    (occupancy != '0) |-> !bypass_ready)
    else $error("bypass taken with occupancy %0d", occupancy);

  // ----------------------------------------------------------
  // Pop handshake
  // ----------------------------------------------------------

  // An offered beat stays offered until the consumer takes it
  a_pop_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (pop_valid && !pop_ready) |=> pop_valid)
    else $error("pop_valid dropped before the beat transferred");

endmodule : fifo_checker

// One checker per pop control instance
bind fifo_pop_ctrl fifo_checker #(.CW(CW)) u_checker (
  .clk          (clk),
  .rst_n        (rst_n),
  .occupancy    (occupancy),
  .capacity     (capacity),
  .bypass_ready (pif.bypass_ready),
  .pop_valid    (pop_valid),
  .pop_ready    (pop_ready)
);

// File: fifo_pkg.sv
// ----------------------------------------------------------
// Shared sizes and types for the synchronous FIFO
// ----------------------------------------------------------

package fifo_pkg;

  // Default number of storage entries in the RAM
  parameter int DEFAULT_DEPTH = 16;

  // Default payload width in bits
  parameter int DEFAULT_WIDTH = 8;

  // Where the beat currently offered on the pop side comes from
  // NONE means pop_valid is low this cycle
  // BYPASS means the push beat is forwarded without storage
  // RAM means the oldest stored entry is presented
  typedef enum logic [1:0] {
    POP_SRC_NONE   = 2'd0,
    POP_SRC_BYPASS = 2'd1,
    POP_SRC_RAM    = 2'd2
  } pop_src_e;

  // Encoding 2'd3 is never produced by the pop control

endpackage : fifo_pkg

// File: fifo_pop_ctrl.sv
`timescale 1ns/1ns

module fifo_pop_ctrl import fifo_pkg::*; #(
  parameter int DEPTH         = 16,
  parameter int WIDTH         = 8,
  parameter bit ENABLE_BYPASS = 1'b1,
  localparam int AW           = $clog2(DEPTH),
  localparam int CW           = $clog2(DEPTH + 1)
) (
  input  logic             clk,
  input  logic             rst_n,

  // Address window, addr_bound is inclusive
  input  logic [AW-1:0]    addr_base,
  input  logic [AW-1:0]    addr_bound,

  // Pop handshake
  input  logic             pop_ready,
  output logic             pop_valid,
  output logic [WIDTH-1:0] pop_data,

  // RAM read port
  output logic [AW-1:0]    ram_rd_addr,
  input  logic [WIDTH-1:0] ram_rd_data,

  fifo_push_if.pop         pif
);

  // Number of entries held in the RAM
  logic [CW-1:0] occupancy;

  // Entries available in the configured window
  logic [CW-1:0] capacity;

  // Current pop source
  pop_src_e      pop_src;

  // Events that move occupancy
  logic          stored_push;
  logic          ram_pop;
  logic          empty;

  // ----------------------------------------------------------
  // Capacity and full
  // ----------------------------------------------------------

  // Window size, bound >= base is assumed
  assign capacity = CW'(addr_bound) - CW'(addr_base) + CW'(1);

  assign empty    = (occupancy == '0);
  assign pif.full = (occupancy == capacity);

  // ----------------------------------------------------------
  // Pop source selection
  // ----------------------------------------------------------

  // Stored data always drains first to keep order
  // Bypass only when nothing is stored
  always_comb begin
    if (!empty) begin
      pop_src = POP_SRC_RAM;
    end else if (ENABLE_BYPASS && pif.bypass_valid) begin
      pop_src = POP_SRC_BYPASS;
    end else begin
      pop_src = POP_SRC_NONE;
    end
  end

  assign pop_valid = (pop_src != POP_SRC_NONE);

  // Take the offered beat only if the consumer takes it too
  assign pif.bypass_ready = (pop_src == POP_SRC_BYPASS) && pop_ready;

  // Data mux
  always_comb begin
    unique case (pop_src)
      POP_SRC_BYPASS: pop_data = pif.bypass_data;
      POP_SRC_RAM:    pop_data = ram_rd_data;
      default:        pop_data = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Occupancy tracking
  // ----------------------------------------------------------

  // A push that did not go through the bypass lands in the RAM
  assign stored_push = pif.push_beat && !pif.bypass_ready;

  // A pop beat served from storage
  assign ram_pop     = pop_ready && (pop_src == POP_SRC_RAM);

  // Both at once leave the count unchanged
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      occupancy <= '0;
    end else if (stored_push && !ram_pop) begin
      occupancy <= occupancy + CW'(1);
    end else if (ram_pop && !stored_push) begin
      occupancy <= occupancy - CW'(1);
    end
  end

  // ----------------------------------------------------------
  // Read address counter
  // ----------------------------------------------------------

  // Follows the write address through the same window
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ram_rd_addr <= addr_base;
    end else if (ram_pop) begin
      if (ram_rd_addr == addr_bound) begin
        ram_rd_addr <= addr_base;
      end else begin
        ram_rd_addr <= ram_rd_addr + AW'(1);
      end
    end
  end

endmodule : fifo_pop_ctrl

// File: fifo_push_ctrl.sv
`timescale 1ns/1ns

module fifo_push_ctrl #(
  parameter int DEPTH         = 16,
  parameter int WIDTH         = 8,
  parameter bit ENABLE_BYPASS = 1'b1,
  localparam int AW           = $clog2(DEPTH)
) (
  input  logic             clk,
  input  logic             rst_n,

  // Push handshake
  input  logic             push_valid,
  input  logic [WIDTH-1:0] push_data,
  output logic             push_ready,

  // Address window, addr_bound is inclusive
  input  logic [AW-1:0]    addr_base,
  input  logic [AW-1:0]    addr_bound,

  // RAM write port
  output logic             ram_wr_valid,
  output logic [AW-1:0]    ram_wr_addr,
  output logic [WIDTH-1:0] ram_wr_data,

  fifo_push_if.push        pif
);

  // ----------------------------------------------------------
  // Flow control
  // ----------------------------------------------------------

  // Accept whenever there is room in the window
  assign push_ready    = !pif.full;
  assign pif.push_beat = push_valid && push_ready;

  // Offer every beat to the pop side, nothing offered without bypass
  assign pif.bypass_valid = ENABLE_BYPASS && push_valid;
  assign pif.bypass_data  = push_data;

  // Store only what the pop side did not take directly
  assign ram_wr_valid = pif.push_beat && !(ENABLE_BYPASS && pif.bypass_ready);
  assign ram_wr_data  = push_data;

  // ----------------------------------------------------------
  // Write address counter
  // ----------------------------------------------------------

  // Walks addr_base .. addr_bound, then back to addr_base
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ram_wr_addr <= addr_base;
    end else if (ram_wr_valid) begin
      if (ram_wr_addr == addr_bound) begin
        ram_wr_addr <= addr_base;
      end else begin
        ram_wr_addr <= ram_wr_addr + AW'(1);
      end
    end
  end

endmodule : fifo_push_ctrl

// File: fifo_push_if.sv
`timescale 1ns/1ns

// Link between push control and pop control
// Carries the accepted beat, the bypass offer and the full flag
interface fifo_push_if #(
  parameter int WIDTH = 8
);

  // High when a push beat transfers this cycle
  logic             push_beat;

  // Bypass offer, follows push_valid so it may drop before a transfer
  logic             bypass_valid;
  logic [WIDTH-1:0] bypass_data;

  // Pop side takes the bypass beat this cycle
  logic             bypass_ready;

  // Occupancy has reached the window capacity
  logic             full;

  // Input side drives the beat and the offer
  modport push (
    output push_beat, bypass_valid, bypass_data,
    input  bypass_ready, full
  );

  // Output side answers the offer and reports full
  modport pop (
    input  push_beat, bypass_valid, bypass_data,
    output bypass_ready, full
  );

endinterface : fifo_push_if

// File: fifo_ram.sv
`timescale 1ns/1ns

// Register array, one write port and one combinational read port
module fifo_ram #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 8,
  localparam int AW   = $clog2(DEPTH)
) (
  input  logic             clk,

  // Write port, takes effect on the next rising edge
  input  logic             wr_valid,
  input  logic [AW-1:0]    wr_addr,
  input  logic [WIDTH-1:0] wr_data,

  // Read port, no latency
  input  logic [AW-1:0]    rd_addr,
  output logic [WIDTH-1:0] rd_data
);

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------

  // Contents are only meaningful once written
  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Same-cycle read of the addressed entry
  // a write to the same entry shows up one cycle later
  assign rd_data = mem[rd_addr];

endmodule : fifo_ram

// File: fifo_top.sv
`timescale 1ns/1ns

module fifo_top import fifo_pkg::*; #(
  parameter int DEPTH         = DEFAULT_DEPTH,
  parameter int WIDTH         = DEFAULT_WIDTH,
  parameter bit ENABLE_BYPASS = 1'b1,
  localparam int AW           = $clog2(DEPTH)
) (
  input  logic             clk,
  input  logic             rst_n,

  // Static address window, change only while in reset
  input  logic [AW-1:0]    addr_base,
  input  logic [AW-1:0]    addr_bound,

  // Push side
  input  logic             push_valid,
  input  logic [WIDTH-1:0] push_data,
  output logic             push_ready,

  // Pop side
  output logic             pop_valid,
  output logic [WIDTH-1:0] pop_data,
  input  logic             pop_ready
);

  // RAM write port
  logic             ram_wr_valid;
  logic [AW-1:0]    ram_wr_addr;
  logic [WIDTH-1:0] ram_wr_data;

  // RAM read port
  logic [AW-1:0]    ram_rd_addr;
  logic [WIDTH-1:0] ram_rd_data;

  // Push to pop control link
  fifo_push_if #(.WIDTH(WIDTH)) push_if ();

  fifo_push_ctrl #(
    .DEPTH         (DEPTH),
    .WIDTH         (WIDTH),
    .ENABLE_BYPASS (ENABLE_BYPASS)
  ) u_push_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .push_ready   (push_ready),
    .addr_base    (addr_base),
    .addr_bound   (addr_bound),
    .ram_wr_valid (ram_wr_valid),
    .ram_wr_addr  (ram_wr_addr),
    .ram_wr_data  (ram_wr_data),
    .pif          (push_if.push)
  );

  fifo_ram #(
    .DEPTH (DEPTH),
    .WIDTH (WIDTH)
  ) u_ram (
    .clk      (clk),
    .wr_valid (ram_wr_valid),
    .wr_addr  (ram_wr_addr),
    .wr_data  (ram_wr_data),
    .rd_addr  (ram_rd_addr),
    .rd_data  (ram_rd_data)
  );

  fifo_pop_ctrl #(
    .DEPTH         (DEPTH),
    .WIDTH         (WIDTH),
    .ENABLE_BYPASS (ENABLE_BYPASS)
  ) u_pop_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .addr_base   (addr_base),
    .addr_bound  (addr_bound),
    .pop_ready   (pop_ready),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .ram_rd_addr (ram_rd_addr),
    .ram_rd_data (ram_rd_data),
    .pif         (push_if.pop)
  );

endmodule : fifo_top

// File: sources.f
fifo_pkg.sv
fifo_push_if.sv
fifo_push_ctrl.sv
fifo_ram.sv
fifo_pop_ctrl.sv
fifo_top.sv
fifo_checker.sv
tb_fifo.sv

// File: tb_fifo.sv
`timescale 1ns/1ns

module tb_fifo;

  localparam int ROWS = 8;

  // One phase of traffic, probabilities are out of 256
  typedef struct packed {
    int base;
    int bound;
    int push_p;
    int pop_p;
    int cycles;
  } phase_t;

  // Window, push rate, pop rate, length
  localparam phase_t PHASES [ROWS] = '{
    '{0, 15, 200, 200, 300},  // random mix over the full window
    '{0, 15, 256, 0,   40},   // fill until push_ready drops
    '{0, 15, 256, 128, 80},   // hover at full, push and pop together
    '{0, 15, 0,   256, 30},   // drain to empty
    '{5, 8,  180, 100, 200},  // narrow window, many wraps
    '{5, 8,  256, 0,   12},   // fill the four-entry window
    '{5, 8,  256, 256, 60},   // streaming through the narrow window
    '{0, 15, 100, 256, 120}   // mostly empty, bypass heavy
  };

  logic       clk;
  logic       rst_n;
  logic [3:0] addr_base;
  logic [3:0] addr_bound;
  logic       push_valid;
  logic [7:0] push_data;
  logic       push_ready;
  logic       pop_valid;
  logic [7:0] pop_data;
  logic       pop_ready;

  // Reference model of the stored beats, head is the next pop
  logic [7:0]  model [$];
  logic [31:0] lfsr;
  logic        hold_push;
  int          errors;
  int          checks;
  int          bypass_cnt;
  int          full_pop_cnt;
  int          pop_cnt;

  fifo_top #(
    .DEPTH         (16),
    .WIDTH         (8),
    .ENABLE_BYPASS (1'b1)
  ) UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr_base  (addr_base),
    .addr_bound (addr_bound),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .pop_ready  (pop_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Random source
  // ----------------------------------------------------------

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
  endtask

  // Table length plus reset overhead, doubled, in ns
  function automatic longint watchdog_ns();
    longint total;
    total = 4 + 4 * ROWS;
    for (int r = 0; r < ROWS; r++) begin
      total += PHASES[r].cycles;
    end
    return total * 8 * 2;
  endfunction

  // ----------------------------------------------------------
  // Reset and checks
  // ----------------------------------------------------------

  // Hold reset for n edges, then expect an idle, empty FIFO
  task automatic finish_reset(input int n);
    repeat (n) @(posedge clk);
    rst_n <= 1'b1;
    model.delete();
    hold_push = 1'b0;
    @(negedge clk);
    checks++;
    if (pop_valid !== 1'b0) begin
      $display("ERR pop_valid expected 0 got %0h after reset", pop_valid);
      errors++;
    end
    if (push_ready !== 1'b1) begin
      $display("ERR push_ready expected 1 got %0h after reset", push_ready);
      errors++;
    end
  endtask

  // Window may only move while the FIFO is held in reset
  task automatic apply_reset(input int base, input int bound);
    @(posedge clk);
    rst_n      <= 1'b0;
    push_valid <= 1'b0;
    pop_ready  <= 1'b0;
    addr_base  <= 4'(base);
    addr_bound <= 4'(bound);
    finish_reset(2);
  endtask

  // Compare outputs with the model, then apply this cycle's transfers
  task automatic check_cycle(input int cap);
    logic       exp_ready;
    logic       exp_valid;
    logic [7:0] exp_data;
    logic       push_fire;
    logic       pop_fire;
    checks++;
    exp_ready = (model.size() != cap);
    exp_valid = (model.size() != 0) || push_valid;
    if (push_ready !== exp_ready) begin
      $display("ERR push_ready expected %0h got %0h", exp_ready, push_ready);
      errors++;
    end
    if (pop_valid !== exp_valid) begin
      $display("ERR pop_valid expected %0h got %0h", exp_valid, pop_valid);
      errors++;
    end
    // Stored head first, otherwise the bypassed push beat
    if (exp_valid) begin
      exp_data = (model.size() != 0) ? model[0] : push_data;
      if (pop_data !== exp_data) begin
        $display("ERR pop_data expected %0h got %0h", exp_data, pop_data);
        errors++;
      end
    end
    push_fire = push_valid && push_ready;
    pop_fire  = pop_valid && pop_ready;
    if (model.size() == 0 && push_fire && pop_fire)
      bypass_cnt++;
    if (!exp_ready && pop_fire)
      full_pop_cnt++;
    if (push_fire)
      model.push_back(push_data);
    if (pop_fire) begin
      pop_cnt++;
      if (model.size() == 0) begin
        $display("Pop beat transferred with nothing pushed");
        errors++;
      end else begin
        void'(model.pop_front());
      end
    end
    hold_push = push_valid && !push_fire;
  endtask

  // Drive one phase, a beat already offered is held until it transfers
  task automatic run_phase(input phase_t ph);
    int r8;
    int d;
    for (int c = 0; c < ph.cycles; c++) begin
      @(posedge clk);
      if (!hold_push) begin
        draw_bits(8, r8);
        draw_bits(8, d);
        push_valid <= (r8 < ph.push_p);
        push_data  <= 8'(d);
      end
      draw_bits(8, r8);
      pop_ready <= (r8 < ph.pop_p);
      @(negedge clk);
      check_cycle(ph.bound - ph.base + 1);
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    rst_n        = 1'b0;
    push_valid   = 1'b0;
    push_data    = 8'h00;
    pop_ready    = 1'b0;
    addr_base    = 4'(PHASES[0].base);
    addr_bound   = 4'(PHASES[0].bound);
    lfsr         = 32'd76367;
    hold_push    = 1'b0;
    errors       = 0;
    checks       = 0;
    bypass_cnt   = 0;
    full_pop_cnt = 0;
    pop_cnt      = 0;
    finish_reset(4);
    for (int r = 0; r < ROWS; r++) begin
      if (r > 0 && (PHASES[r].base != PHASES[r-1].base ||
                    PHASES[r].bound != PHASES[r-1].bound)) begin
        apply_reset(PHASES[r].base, PHASES[r].bound);
      end
      run_phase(PHASES[r]);
    end
    // Traffic must have reached the interesting corners
    if (bypass_cnt == 0) begin
      $display("No beat ever went through the bypass path");
      errors++;
    end
    if (full_pop_cnt == 0) begin
      $display("No pop ever happened while the FIFO was full");
      errors++;
    end
    $display("Checked %0d cycles, %0d pops, %0d bypass, %0d errors",
             checks, pop_cnt, bypass_cnt, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Stop a stuck run
  initial begin
    #(watchdog_ns());
    $display("Watchdog expired before the test sequence ended");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule : tb_fifo
